// ==== source/lsuPkg.sv ====
// geometry is fixed at 8 sets of 2 ways with 16-byte lines and 32-bit addresses
package lsuPkg;

    // cache geometry
    localparam int ADDR_W     = 32;
    localparam int OFFSET_W   = 4;
    localparam int SET_W      = 3;
    localparam int NUM_SETS   = 8;
    localparam int NUM_WAYS   = 2;
    localparam int WAY_W      = 1;
    localparam int TAG_W      = ADDR_W - SET_W - OFFSET_W;
    localparam int NUM_LINES  = NUM_SETS * NUM_WAYS;
    localparam int LINE_IDX_W = WAY_W + SET_W;

    // commands towards the external memory controller
    typedef enum logic [1:0] {
        MEMC_NONE,
        MEMC_REPLACE,
        MEMC_CP_EXT_TO_CACHE,
        MEMC_CP_CACHE_TO_EXT
    } memcCmd;

    typedef enum logic [1:0] {
        MISS_NONE,
        MISS_REGULAR,
        MISS_NO_EVICT,
        MISS_BUSY
    } missKind;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } ldReq;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
        logic [3:0]        wmask;
    } stReq;

    // one acknowledge per accepted request
    typedef struct packed {
        logic             valid;
        logic             isStore;
        logic             hit;
        logic             fail;
        missKind          kind;
        logic [WAY_W-1:0] way;
    } lsuAck;

    // cacheLine is {way, set}, mask and data carry a fused store
    typedef struct packed {
        memcCmd                cmd;
        logic [LINE_IDX_W-1:0] cacheLine;
        logic [ADDR_W-1:0]     readAddr;
        logic [ADDR_W-1:0]     writeAddr;
        logic [3:0]            mask;
        logic [31:0]           data;
    } memcReq;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagEntry;

    typedef struct packed {
        logic             we;
        logic [SET_W-1:0] set;
        logic [WAY_W-1:0] way;
        tagEntry          entry;
    } tagWrite;

    // request held between the access port and the miss handler
    typedef struct packed {
        logic              valid;
        logic              isStore;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
        logic [3:0]        wmask;
    } accessOp;

endpackage

// ==== source/cacheTagTable.sv ====
// contents are undefined after reset until the initial flush has invalidated every entry
`timescale 1ns/100ps

module cacheTagTable (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [lsuPkg::SET_W-1:0]                    rdSet,
    output lsuPkg::tagEntry [lsuPkg::NUM_WAYS-1:0]      rdEntries,
    input  lsuPkg::tagWrite                             wr
);
    import lsuPkg::*;

    // one row per set, all ways side by side
    tagEntry [NUM_WAYS-1:0] tags [NUM_SETS];

    // read is registered, a write in the same cycle is seen one cycle later
    always_ff @(posedge clk) begin
        rdEntries <= tags[rdSet];
    end

    // writes are dropped while reset is held
    always_ff @(posedge clk) begin
        if (wr.we && !rst) begin
            tags[wr.set][wr.way] <= wr.entry;
        end
    end

endmodule

// ==== source/accessPort.sv ====
// loads always win the table read port, a stalled request must be held by the host
`timescale 1ns/100ps

module accessPort (
    input  logic                        clk,
    input  logic                        rst,
    input  lsuPkg::ldReq                ld,
    input  lsuPkg::stReq                st,
    output logic                        ldStall,
    output logic                        stStall,
    input  logic                        tableWriting,
    input  logic                        flushActive,
    input  logic [lsuPkg::SET_W-1:0]    flushSet,
    output logic [lsuPkg::SET_W-1:0]    rdSet,
    output lsuPkg::accessOp             op
);
    import lsuPkg::*;

    logic blocked;
    logic ldGo;
    logic stGo;

    // the table port is taken by the flush walker or by a miss write
    assign blocked = flushActive || tableWriting;

    assign ldStall = blocked;
    assign stStall = blocked || ld.valid;

    assign ldGo = ld.valid && !ldStall;
    assign stGo = st.valid && !stStall;

    always_comb begin
        if (flushActive) begin
            rdSet = flushSet;
        end else if (ld.valid) begin
            rdSet = ld.addr[OFFSET_W +: SET_W];
        end else begin
            rdSet = st.addr[OFFSET_W +: SET_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= ldGo || stGo;
        end
    end

    // payload of the accepted request
    always_ff @(posedge clk) begin
        if (ldGo) begin
            op.isStore <= 1'b0;
            op.addr    <= ld.addr;
            op.data    <= '0;
            op.wmask   <= '0;
        end else if (stGo) begin
            op.isStore <= 1'b1;
            op.addr    <= st.addr;
            op.data    <= st.data;
            op.wmask   <= st.wmask;
        end
    end

endmodule

// ==== source/missHandler.sv ====
// a miss while a command waits under stall or while a flush runs is failed as busy and retried
`timescale 1ns/100ps

module missHandler (
    input  logic                                    clk,
    input  logic                                    rst,
    input  lsuPkg::accessOp                         op,
    input  lsuPkg::tagEntry [lsuPkg::NUM_WAYS-1:0]  entries,
    input  logic                                    flushActive,
    input  lsuPkg::tagWrite                         flushWr,
    input  logic                                    wbValid,
    input  logic [lsuPkg::LINE_IDX_W-1:0]           wbLine,
    input  logic [lsuPkg::ADDR_W-1:0]               wbAddr,
    input  logic                                    memcStall,
    output lsuPkg::lsuAck                           ack,
    output lsuPkg::tagWrite                         tableWr,
    output logic                                    tableWriting,
    output logic                                    flushDirty,
    output logic                                    cmdPending,
    output lsuPkg::memcReq                          memc
);
    import lsuPkg::*;

    logic [SET_W-1:0]      opSet;
    logic [TAG_W-1:0]      opTag;
    logic                  hit;
    logic [WAY_W-1:0]      hitWay;
    logic [WAY_W-1:0]      victimCnt;
    tagEntry               victimEntry;
    logic [LINE_IDX_W-1:0] victimLine;
    logic                  evict;
    logic                  canTake;
    logic                  blocked;
    logic                  isMiss;
    logic                  doMiss;
    logic                  storeHit;
    logic [NUM_LINES-1:0]  dirty;
    tagWrite               missWr;
    memcReq                nextMemc;

    assign opSet = op.addr[OFFSET_W +: SET_W];
    assign opTag = op.addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        hit    = 1'b0;
        hitWay = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (entries[w].valid && entries[w].tag == opTag) begin
                hit    = 1'b1;
                hitWay = WAY_W'(w);
            end
        end
    end

    // victim from the shared round-robin counter
    assign victimEntry = entries[victimCnt];
    assign victimLine  = {victimCnt, opSet};
    assign evict       = victimEntry.valid && dirty[victimLine];

    // the command register frees up when empty or not stalled
    assign cmdPending = (memc.cmd != MEMC_NONE);
    assign canTake    = !cmdPending || !memcStall;
    assign blocked    = !canTake || flushActive;

    assign isMiss   = op.valid && !hit;
    assign doMiss   = isMiss && !blocked;
    assign storeHit = op.valid && op.isStore && hit;

    always_comb begin
        ack.valid   = op.valid;
        ack.isStore = op.isStore;
        ack.hit     = op.valid && hit;
        // fused store misses complete, load misses are retried
        ack.fail    = isMiss && (!op.isStore || blocked);
        ack.way     = hit ? hitWay : victimCnt;
        if (!isMiss) begin
            ack.kind = MISS_NONE;
        end else if (blocked) begin
            ack.kind = MISS_BUSY;
        end else if (victimEntry.valid) begin
            ack.kind = MISS_REGULAR;
        end else begin
            ack.kind = MISS_NO_EVICT;
        end
    end

    // new tag goes in right away
    always_comb begin
        missWr.we          = doMiss;
        missWr.set         = opSet;
        missWr.way         = victimCnt;
        missWr.entry.valid = 1'b1;
        missWr.entry.tag   = opTag;
    end

    assign tableWr      = flushActive ? flushWr : missWr;
    assign tableWriting = tableWr.we;

    assign flushDirty = dirty[wbLine];

    always_comb begin
        nextMemc     = '0;
        nextMemc.cmd = MEMC_NONE;
        if (flushActive) begin
            if (wbValid) begin
                nextMemc.cmd       = MEMC_CP_CACHE_TO_EXT;
                nextMemc.cacheLine = wbLine;
                nextMemc.writeAddr = wbAddr;
            end
        end else if (doMiss) begin
            nextMemc.cmd       = evict ? MEMC_REPLACE : MEMC_CP_EXT_TO_CACHE;
            nextMemc.cacheLine = victimLine;
            nextMemc.readAddr  = {op.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            if (evict) begin
                nextMemc.writeAddr = {victimEntry.tag, opSet, {OFFSET_W{1'b0}}};
            end
            // store data is spliced into the fill by the controller
            if (op.isStore) begin
                nextMemc.mask = op.wmask;
                nextMemc.data = op.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memc.cmd <= MEMC_NONE;
        end else if (canTake) begin
            memc <= nextMemc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty     <= '0;
            victimCnt <= '0;
        end else begin
            if (storeHit) begin
                dirty[{hitWay, opSet}] <= 1'b1;
            end
            // a refilled line is dirty only if a store was fused in
            if (doMiss) begin
                dirty[victimLine] <= op.isStore;
                victimCnt         <= victimCnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/flushWalker.sv ====
// the walk after reset only invalidates, later walks also write back dirty valid lines
`timescale 1ns/100ps

module flushWalker (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    flush,
    input  logic                                    memcStall,
    input  logic                                    cmdPending,
    input  lsuPkg::tagEntry [lsuPkg::NUM_WAYS-1:0]  entries,
    input  logic                                    dirty,
    output logic                                    active,
    output logic                                    busy,
    output logic [lsuPkg::SET_W-1:0]                rdSet,
    output lsuPkg::tagWrite                         wr,
    output logic                                    wbValid,
    output logic [lsuPkg::LINE_IDX_W-1:0]           wbLine,
    output logic [lsuPkg::ADDR_W-1:0]               wbAddr
);
    import lsuPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        READ,
        WALK,
        FINAL
    } flushState;

    flushState        state;
    logic             initialFlush;
    logic             flushQueued;
    logic [SET_W-1:0] set;
    logic [WAY_W-1:0] way;
    logic             canStep;
    logic             lastWay;
    logic             lastSet;

    assign canStep = !cmdPending || !memcStall;
    assign lastWay = (way == WAY_W'(NUM_WAYS - 1));
    assign lastSet = (set == SET_W'(NUM_SETS - 1));

    assign active = (state != IDLE);
    assign busy   = flushQueued || active;
    assign rdSet  = set;

    // invalidate only on the step so a stalled way keeps its tag for the writeback
    always_comb begin
        wr.we    = (state == WALK) && canStep;
        wr.set   = set;
        wr.way   = way;
        wr.entry = '0;
    end

    assign wbValid = (state == WALK) && entries[way].valid && dirty && !initialFlush;
    assign wbLine  = {way, set};
    assign wbAddr  = {entries[way].tag, set, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WAIT;
            initialFlush <= 1'b1;
            flushQueued  <= 1'b0;
            set          <= '0;
            way          <= '0;
        end else begin
            // a pulse during the walk starts another walk afterwards
            if (flush && (state == READ || state == WALK)) begin
                flushQueued <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (flush) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (!cmdPending) begin
                        state <= READ;
                        set   <= '0;
                        way   <= '0;
                    end
                end
                READ: state <= WALK;
                WALK: begin
                    if (canStep) begin
                        if (lastWay) begin
                            way <= '0;
                            if (lastSet) begin
                                state <= FINAL;
                            end else begin
                                set   <= set + 1'b1;
                                state <= READ;
                            end
                        end else begin
                            way <= way + 1'b1;
                        end
                    end
                end
                FINAL: begin
                    initialFlush <= 1'b0;
                    flushQueued  <= 1'b0;
                    state        <= (flushQueued || flush) ? WAIT : IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== source/loadStoreUnit.sv ====
// the cache data array and the memory controller sit outside, the controller only gives a stall
`timescale 1ns/100ps

module loadStoreUnit (
    input  logic            clk,
    input  logic            rst,
    input  lsuPkg::ldReq    ld,
    input  lsuPkg::stReq    st,
    input  logic            flush,
    input  logic            memcStall,
    output logic            ldStall,
    output logic            stStall,
    output logic            busy,
    output lsuPkg::lsuAck   ack,
    output lsuPkg::memcReq  memc
);
    import lsuPkg::*;

    tagEntry [NUM_WAYS-1:0] entries;
    accessOp                op;
    tagWrite                tableWr;
    tagWrite                flushWr;
    logic [SET_W-1:0]       tableRdSet;
    logic [SET_W-1:0]       flushSet;
    logic                   tableWriting;
    logic                   flushActive;
    logic                   flushDirty;
    logic                   cmdPending;
    logic                   wbValid;
    logic [LINE_IDX_W-1:0]  wbLine;
    logic [ADDR_W-1:0]      wbAddr;

    cacheTagTable u_tagTable (
        .clk       (clk),
        .rst       (rst),
        .rdSet     (tableRdSet),
        .rdEntries (entries),
        .wr        (tableWr)
    );

    accessPort u_accessPort (
        .clk          (clk),
        .rst          (rst),
        .ld           (ld),
        .st           (st),
        .ldStall      (ldStall),
        .stStall      (stStall),
        .tableWriting (tableWriting),
        .flushActive  (flushActive),
        .flushSet     (flushSet),
        .rdSet        (tableRdSet),
        .op           (op)
    );

    missHandler u_missHandler (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .entries      (entries),
        .flushActive  (flushActive),
        .flushWr      (flushWr),
        .wbValid      (wbValid),
        .wbLine       (wbLine),
        .wbAddr       (wbAddr),
        .memcStall    (memcStall),
        .ack          (ack),
        .tableWr      (tableWr),
        .tableWriting (tableWriting),
        .flushDirty   (flushDirty),
        .cmdPending   (cmdPending),
        .memc         (memc)
    );

    flushWalker u_flushWalker (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .memcStall  (memcStall),
        .cmdPending (cmdPending),
        .entries    (entries),
        .dirty      (flushDirty),
        .active     (flushActive),
        .busy       (busy),
        .rdSet      (flushSet),
        .wr         (flushWr),
        .wbValid    (wbValid),
        .wbLine     (wbLine),
        .wbAddr     (wbAddr)
    );

endmodule

// ==== dv/lsuChecks_properties.sv ====
// bound to loadStoreUnit, reset must be synchronous and the checks are off while it is held
`timescale 1ns/100ps

module lsuChecks (
    input  logic            clk,
    input  logic            rst,
    input  lsuPkg::lsuAck   ack,
    input  lsuPkg::memcReq  memc,
    input  logic            memcStall,
    input  logic            busy,
    input  logic            ldStall,
    input  logic            stStall
);
    import lsuPkg::*;

    // no acknowledge can come out of a cleared request register
    ackQuietAfterReset: assert property (@(posedge clk) rst |=> !ack.valid)
        else $error("acknowledge valid in the cycle after reset");

    // back-pressure freezes the whole command
    cmdHeldUnderStall: assert property (@(posedge clk) disable iff (rst)
        (memc.cmd != MEMC_NONE && memcStall) |=> $stable(memc))
        else $error("memory command changed while the controller stalled");

    // both host ports wait while a flush is queued or walking
    stallWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> (ldStall && stStall))
        else $error("a host port was not stalled while busy");

endmodule

bind loadStoreUnit lsuChecks u_lsuChecks (.*);

// ==== dv/loadStoreUnitTb.sv ====
// one request at a time with memcStall changed only between rows, random pass runs with no stall
`timescale 1ns/100ps

module loadStoreUnitTb;
    import lsuPkg::*;

    localparam int TABLE_ROWS   = 13;
    localparam int RAND_OPS     = 24;
    localparam int FLUSHES      = 3;
    localparam int OP_CYCLES    = 8;
    localparam int FLUSH_CYCLES = 3 * NUM_LINES + 8;
    localparam int CYCLE_LIMIT  = 10 + (TABLE_ROWS + RAND_OPS) * OP_CYCLES
                                  + FLUSHES * FLUSH_CYCLES;

    // op is 0 for a load, 1 for a store and 2 for a flush pulse
    typedef struct {
        int          op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic        stall;
        logic        hit;
        logic        fail;
        missKind     mk;
        logic        way;
        memcCmd      cmd;
        logic [31:0] wrAddr;
        int          wbCount;
    } row;

    logic   clk;
    logic   rst;
    ldReq   ld;
    stReq   st;
    logic   flush;
    logic   memcStall;
    logic   ldStall;
    logic   stStall;
    logic   busy;
    lsuAck  ack;
    memcReq memc;

    row          rows[$];
    int          cycles;
    logic [31:0] lcgState;

    // reference model of the tag table
    logic [TAG_W-1:0] modelTag   [NUM_SETS][NUM_WAYS];
    logic             modelValid [NUM_SETS][NUM_WAYS];
    logic             modelDirty [NUM_LINES];
    logic             modelCnt;
    logic             modelPend;

    loadStoreUnit u_loadStoreUnit (
        .clk       (clk),
        .rst       (rst),
        .ld        (ld),
        .st        (st),
        .flush     (flush),
        .memcStall (memcStall),
        .ldStall   (ldStall),
        .stStall   (stStall),
        .busy      (busy),
        .ack       (ack),
        .memc      (memc)
    );

    always #10 clk = ~clk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            stopRun("the run took too many cycles and was stopped");
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic addRow(input int op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] mask, input logic stall, input logic hit,
                          input logic fail, input missKind mk, input logic way,
                          input memcCmd cmd, input logic [31:0] wrAddr, input int wbCount);
        row r;
        r = '{op, addr, data, mask, stall, hit, fail, mk, way, cmd, wrAddr, wbCount};
        rows.push_back(r);
    endtask

    // fills the expected fields from the model and updates it
    task automatic predict(inout row r);
        logic [SET_W-1:0] s;
        logic [TAG_W-1:0] t;
        logic             busyNow;
        logic             v;
        s         = r.addr[6:4];
        t         = r.addr[31:7];
        r.hit     = 1'b0;
        r.fail    = 1'b0;
        r.mk      = MISS_NONE;
        r.way     = modelCnt;
        r.cmd     = MEMC_NONE;
        r.wrAddr  = '0;
        busyNow   = modelPend && r.stall;
        if (!r.stall) begin
            modelPend = 1'b0;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (modelValid[s][w] && modelTag[s][w] == t) begin
                r.hit = 1'b1;
                r.way = 1'(w);
            end
        end
        if (r.hit) begin
            if (r.op == 1) begin
                modelDirty[{r.way, s}] = 1'b1;
            end
        end else if (busyNow) begin
            r.mk   = MISS_BUSY;
            r.fail = 1'b1;
        end else begin
            v      = modelCnt;
            r.mk   = modelValid[s][v] ? MISS_REGULAR : MISS_NO_EVICT;
            r.fail = (r.op == 0);
            if (modelValid[s][v] && modelDirty[{v, s}]) begin
                r.cmd    = MEMC_REPLACE;
                r.wrAddr = {modelTag[s][v], s, 4'h0};
            end else begin
                r.cmd = MEMC_CP_EXT_TO_CACHE;
            end
            modelTag[s][v]     = t;
            modelValid[s][v]   = 1'b1;
            modelDirty[{v, s}] = (r.op == 1);
            modelCnt           = ~modelCnt;
            modelPend          = r.stall;
        end
    endtask

    // returns the writebacks a flush should issue and invalidates the model
    task automatic flushModel(output int count);
        count = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (modelValid[s][w] && modelDirty[w * NUM_SETS + s]) begin
                    count++;
                end
                modelValid[s][w] = 1'b0;
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic waitFlushDone(input int expWb);
        int               count;
        logic [SET_W-1:0] s;
        logic             w;
        count = 0;
        while (busy) begin
            @(negedge clk);
            s = memc.cacheLine[SET_W-1:0];
            w = memc.cacheLine[LINE_IDX_W-1];
            if (memc.cmd == MEMC_CP_CACHE_TO_EXT) begin
                count++;
                // a written back line carries the tag it held before the flush
                assert (modelDirty[memc.cacheLine] && memc.writeAddr == {modelTag[s][w], s, 4'h0})
                    else stopRun($sformatf("[ERROR] %0t ns: writeback of line %h to %h is wrong",
                                           $time, memc.cacheLine, memc.writeAddr));
            end else begin
                assert (memc.cmd == MEMC_NONE) else
                    stopRun($sformatf("[ERROR] %0t ns: command %s during a flush",
                                      $time, memc.cmd.name()));
            end
        end
        assert (count == expWb) else
            stopRun($sformatf("[ERROR] %0t ns: flush wrote back %0d lines, expected %0d",
                              $time, count, expWb));
    endtask

    task automatic applyRequest(input row r, output lsuAck a, output memcReq m,
                                output memcReq held);
        memcStall = r.stall;
        held      = memc;
        if (r.op == 0) begin
            ld.valid = 1'b1;
            ld.addr  = r.addr;
        end else begin
            st = '{valid: 1'b1, addr: r.addr, data: r.data, wmask: r.mask};
        end
        #5;
        while ((r.op == 0) ? ldStall : stStall) begin
            @(negedge clk);
            #5;
        end
        @(negedge clk);
        ld = '0;
        st = '0;
        a  = ack;
        @(negedge clk);
        m = memc;
    endtask

    task automatic checkResult(input row e, input lsuAck a, input memcReq m,
                               input memcReq held);
        assert (a.valid && a.isStore == (e.op == 1) && a.hit == e.hit && a.fail == e.fail
                && a.kind == e.mk && a.way == e.way) else
            stopRun({$sformatf("[ERROR] %0t ns: ack for %h is hit %0b fail %0b kind %s way %0d",
                               $time, e.addr, a.hit, a.fail, a.kind.name(), a.way),
                     $sformatf(", expected hit %0b fail %0b kind %s way %0d",
                               e.hit, e.fail, e.mk.name(), e.way)});
        if (e.mk == MISS_BUSY) begin
            assert (m == held) else
                stopRun($sformatf("[ERROR] %0t ns: held command changed on busy miss at %h",
                                  $time, e.addr));
        end else begin
            assert (m.cmd == e.cmd) else
                stopRun($sformatf("[ERROR] %0t ns: command %s for %h, expected %s",
                                  $time, m.cmd.name(), e.addr, e.cmd.name()));
        end
        if (e.cmd != MEMC_NONE) begin
            assert (m.cacheLine == {e.way, e.addr[6:4]} && m.readAddr == {e.addr[31:4], 4'h0})
                else stopRun($sformatf("[ERROR] %0t ns: line %h or read address %h wrong for %h",
                                       $time, m.cacheLine, m.readAddr, e.addr));
            if (e.cmd == MEMC_REPLACE) begin
                assert (m.writeAddr == e.wrAddr) else
                    stopRun($sformatf("[ERROR] %0t ns: write address %h, expected %h",
                                      $time, m.writeAddr, e.wrAddr));
            end
            if (e.op == 1) begin
                assert (m.mask == e.mask && m.data == e.data) else
                    stopRun($sformatf("[ERROR] %0t ns: fused store mask %h data %h wrong",
                                      $time, m.mask, m.data));
            end
        end
    endtask

    initial begin
        row     r;
        row     e;
        lsuAck  a;
        memcReq m;
        memcReq held;
        int     wb;
        clk       = 1'b0;
        rst       = 1'b1;
        ld        = '0;
        st        = '0;
        flush     = 1'b0;
        memcStall = 1'b0;
        cycles    = 0;
        lcgState  = 32'hf06503b6;
        modelCnt  = 1'b0;
        modelPend = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                modelValid[s][w] = 1'b0;
                modelTag[s][w]   = '0;
            end
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            modelDirty[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (busy) else stopRun("busy was low right after reset");
        waitFlushDone(0);

        addRow(0, 32'h1000, 0, 0, 0, 0, 1, MISS_NO_EVICT, 0, MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(0, 32'h1000, 0, 0, 0, 1, 0, MISS_NONE, 0, MEMC_NONE, 0, 0);
        addRow(1, 32'h1004, 32'hdeadbeef, 4'hf, 0, 1, 0, MISS_NONE, 0, MEMC_NONE, 0, 0);
        addRow(0, 32'h2000, 0, 0, 0, 0, 1, MISS_NO_EVICT, 1, MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(0, 32'h3000, 0, 0, 0, 0, 1, MISS_REGULAR, 0, MEMC_REPLACE, 32'h1000, 0);
        addRow(1, 32'h4020, 32'h12345678, 4'h3, 0, 0, 0, MISS_NO_EVICT, 1,
               MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(1, 32'h4024, 32'h0badf00d, 4'hc, 0, 1, 0, MISS_NONE, 1, MEMC_NONE, 0, 0);
        addRow(0, 32'h5000, 0, 0, 1, 0, 1, MISS_REGULAR, 0, MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(0, 32'h6000, 0, 0, 1, 0, 1, MISS_BUSY, 1, MEMC_NONE, 0, 0);
        addRow(0, 32'h6000, 0, 0, 0, 0, 1, MISS_REGULAR, 1, MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(2, 0, 0, 0, 0, 0, 0, MISS_NONE, 0, MEMC_NONE, 0, 1);
        addRow(0, 32'h1000, 0, 0, 0, 0, 1, MISS_NO_EVICT, 0, MEMC_CP_EXT_TO_CACHE, 0, 0);
        addRow(0, 32'h4020, 0, 0, 0, 0, 1, MISS_NO_EVICT, 1, MEMC_CP_EXT_TO_CACHE, 0, 0);

        foreach (rows[i]) begin
            r = rows[i];
            e = r;
            if (r.op == 2) begin
                memcStall = 1'b0;
                flush     = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                assert (busy && ldStall && stStall) else
                    stopRun("a flush pulse did not raise busy and stall both ports");
                flushModel(wb);
                waitFlushDone(r.wbCount);
            end else begin
                // the model follows along so the random pass starts from the same state
                predict(e);
                applyRequest(r, a, m, held);
                checkResult(r, a, m, held);
            end
        end

        for (int i = 0; i < RAND_OPS; i++) begin
            logic [31:0] x;
            x = nextRand();
            r.op      = x[20] ? 1 : 0;
            r.addr    = {13'h0010, 10'h0, x[9:8], x[6:4], x[3:2], 2'b00};
            r.data    = nextRand();
            r.mask    = x[27:24];
            r.stall   = 1'b0;
            r.wbCount = 0;
            predict(r);
            applyRequest(r, a, m, held);
            checkResult(r, a, m, held);
        end

        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        flushModel(wb);
        waitFlushDone(wb);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/lsuPkg.sv
source/cacheTagTable.sv
source/accessPort.sv
source/missHandler.sv
source/flushWalker.sv
source/loadStoreUnit.sv
dv/lsuChecks_properties.sv
dv/loadStoreUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module loadStoreUnitTb -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "^Everything OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
